/* src/heading_pkg.sv */
package heading_pkg;

    //////////////////////////////
    // Ratio and divider sizing
    localparam int RATIO_BITS  = 6;
    localparam int DIV_STEPS   = 7;
    localparam int TABLE_DEPTH = 65;

    //////////////////////////////
    // Angle constants in degrees
    localparam int RIGHT_ANGLE = 90;
    localparam int HALF_CIRCLE = 180;
    localparam int FULL_CIRCLE = 360;

    typedef logic signed [15:0]       axis_t;
    typedef logic        [15:0]       mag_t;
    typedef logic        [RATIO_BITS:0] ratio_idx_t;
    typedef logic        [8:0]        angle_t;

    // Bit 1 is the sign of y, bit 0 is set when x and y differ in sign
    typedef logic        [1:0]        quadrant_t;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_HOLD,
        CAP_RELEASE
    } capture_state_t;

    typedef enum logic [2:0] {
        CORE_IDLE,
        CORE_FOLD,
        CORE_DIVIDE,
        CORE_LOOKUP,
        CORE_COMPOSE,
        CORE_PRESENT,
        CORE_RETIRE
    } core_state_t;

endpackage

/* src/sample_capture.sv */
`timescale 1ns/10ps

module sample_capture (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               sample_req,
    input  heading_pkg::axis_t x_in,
    input  heading_pkg::axis_t y_in,
    input  logic               busy,
    output logic               sample_ack,
    output heading_pkg::axis_t x_lat,
    output heading_pkg::axis_t y_lat,
    output logic               start
);
    import heading_pkg::*;

    capture_state_t state;
    logic           accept;

    // New sample taken only when the core is free
    assign accept = (state == CAP_IDLE) && sample_req && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= CAP_IDLE;
            sample_ack <= 1'b0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                CAP_IDLE: begin
                    if (accept) begin
                        sample_ack <= 1'b1;
                        start      <= 1'b1;
                        state      <= CAP_HOLD;
                    end
                end
                CAP_HOLD: begin
                    // Wait for the sender to drop its request
                    if (!sample_req) begin
                        sample_ack <= 1'b0;
                        state      <= CAP_RELEASE;
                    end
                end
                CAP_RELEASE: begin
                    state <= CAP_IDLE;
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            x_lat <= x_in;
            y_lat <= y_in;
        end
    end

    // Ack only answers a request that was present
    ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(sample_ack) |-> $past(sample_req));

endmodule

/* src/octant_fold.sv */
`timescale 1ns/10ps

module octant_fold (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  heading_pkg::axis_t     x_lat,
    input  heading_pkg::axis_t     y_lat,
    output heading_pkg::mag_t      min_mag,
    output heading_pkg::mag_t      max_mag,
    output logic                   swapped,
    output heading_pkg::quadrant_t quadrant
);
    import heading_pkg::*;

    mag_t abs_x;
    mag_t abs_y;
    logic y_larger;

    // True magnitudes, -32768 folds to 32768
    always_comb begin
        abs_x    = x_lat[15] ? mag_t'(~x_lat) + 16'd1 : mag_t'(x_lat);
        abs_y    = y_lat[15] ? mag_t'(~y_lat) + 16'd1 : mag_t'(y_lat);
        y_larger = abs_y > abs_x;
    end

    //////////////////////////////
    // Quadrant and swap flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            quadrant <= '0;
            swapped  <= 1'b0;
        end else if (start) begin
            quadrant <= {y_lat[15], x_lat[15] ^ y_lat[15]};
            swapped  <= y_larger;
        end
    end

    //////////////////////////////
    // Ordered magnitudes
    always_ff @(posedge clk) begin
        if (start) begin
            if (y_larger) begin
                min_mag <= abs_x;
                max_mag <= abs_y;
            end else begin
                min_mag <= abs_y;
                max_mag <= abs_x;
            end
        end
    end

    // Divider relies on a ratio no greater than one
    fold_ordered: assert property (@(posedge clk) disable iff (!arst_n)
        start |=> (min_mag <= max_mag));

endmodule

/* src/ratio_divider.sv */
`timescale 1ns/10ps

module ratio_divider (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    div_start,
    input  heading_pkg::mag_t       min_mag,
    input  heading_pkg::mag_t       max_mag,
    output heading_pkg::ratio_idx_t ratio_idx,
    output logic                    div_done
);
    import heading_pkg::*;

    logic       active;
    logic [2:0] step_cnt;

    logic [16:0] rem_q;
    mag_t        divisor_q;
    ratio_idx_t  quot_q;
    logic        zero_div;

    logic [16:0] trial;
    mag_t        trial_d;
    logic        fits;
    logic [16:0] rem_next;

    //////////////////////////////
    // One restoring step per cycle
    // First step runs on the start cycle straight from the inputs
    always_comb begin
        trial    = div_start ? {1'b0, min_mag} : rem_q;
        trial_d  = div_start ? max_mag : divisor_q;
        fits     = trial >= {1'b0, trial_d};
        rem_next = fits ? trial - {1'b0, trial_d} : trial;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            step_cnt <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                active   <= 1'b1;
                step_cnt <= 3'd1;
            end else if (active) begin
                step_cnt <= step_cnt + 3'd1;
                if (step_cnt == 3'(DIV_STEPS - 1)) begin
                    active   <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    // Remainder stays below the divisor, so the shift never overflows
    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor_q <= max_mag;
            zero_div  <= (max_mag == '0);
            quot_q    <= ratio_idx_t'(fits);
            rem_q     <= {rem_next[15:0], 1'b0};
        end else if (active) begin
            quot_q <= {quot_q[RATIO_BITS-1:0], fits};
            rem_q  <= {rem_next[15:0], 1'b0};
        end
    end

    // Zero vector has no direction, index 0
    assign ratio_idx = zero_div ? '0 : quot_q;

    ratio_in_table: assert property (@(posedge clk) disable iff (!arst_n)
        div_done |-> (ratio_idx <= ratio_idx_t'(TABLE_DEPTH - 1)));

endmodule

/* src/atan_rom.sv */
`timescale 1ns/10ps

module atan_rom (
    input  logic                    clk,
    input  heading_pkg::ratio_idx_t addr,
    output heading_pkg::angle_t     table_angle
);

    // atan(addr/64) in whole degrees, rounded to nearest
    always_ff @(posedge clk) begin
        case (addr)
            7'd0:    table_angle <= 9'd0;
            7'd1:    table_angle <= 9'd1;
            7'd2:    table_angle <= 9'd2;
            7'd3:    table_angle <= 9'd3;
            7'd4:    table_angle <= 9'd4;
            7'd5:    table_angle <= 9'd4;
            7'd6:    table_angle <= 9'd5;
            7'd7:    table_angle <= 9'd6;
            7'd8:    table_angle <= 9'd7;
            7'd9:    table_angle <= 9'd8;
            7'd10:   table_angle <= 9'd9;
            7'd11:   table_angle <= 9'd10;
            7'd12:   table_angle <= 9'd11;
            7'd13:   table_angle <= 9'd11;
            7'd14:   table_angle <= 9'd12;
            7'd15:   table_angle <= 9'd13;
            7'd16:   table_angle <= 9'd14;
            7'd17:   table_angle <= 9'd15;
            7'd18:   table_angle <= 9'd16;
            7'd19:   table_angle <= 9'd17;
            7'd20:   table_angle <= 9'd17;
            7'd21:   table_angle <= 9'd18;
            7'd22:   table_angle <= 9'd19;
            7'd23:   table_angle <= 9'd20;
            7'd24:   table_angle <= 9'd21;
            7'd25:   table_angle <= 9'd21;
            7'd26:   table_angle <= 9'd22;
            7'd27:   table_angle <= 9'd23;
            7'd28:   table_angle <= 9'd24;
            7'd29:   table_angle <= 9'd24;
            7'd30:   table_angle <= 9'd25;
            7'd31:   table_angle <= 9'd26;
            7'd32:   table_angle <= 9'd27;
            7'd33:   table_angle <= 9'd27;
            7'd34:   table_angle <= 9'd28;
            7'd35:   table_angle <= 9'd29;
            7'd36:   table_angle <= 9'd29;
            7'd37:   table_angle <= 9'd30;
            7'd38:   table_angle <= 9'd31;
            7'd39:   table_angle <= 9'd31;
            7'd40:   table_angle <= 9'd32;
            7'd41:   table_angle <= 9'd33;
            7'd42:   table_angle <= 9'd33;
            7'd43:   table_angle <= 9'd34;
            7'd44:   table_angle <= 9'd35;
            7'd45:   table_angle <= 9'd35;
            7'd46:   table_angle <= 9'd36;
            7'd47:   table_angle <= 9'd36;
            7'd48:   table_angle <= 9'd37;
            7'd49:   table_angle <= 9'd37;
            7'd50:   table_angle <= 9'd38;
            7'd51:   table_angle <= 9'd39;
            7'd52:   table_angle <= 9'd39;
            7'd53:   table_angle <= 9'd40;
            7'd54:   table_angle <= 9'd40;
            7'd55:   table_angle <= 9'd41;
            7'd56:   table_angle <= 9'd41;
            7'd57:   table_angle <= 9'd42;
            7'd58:   table_angle <= 9'd42;
            7'd59:   table_angle <= 9'd43;
            7'd60:   table_angle <= 9'd43;
            7'd61:   table_angle <= 9'd44;
            7'd62:   table_angle <= 9'd44;
            7'd63:   table_angle <= 9'd45;
            7'd64:   table_angle <= 9'd45;
            // Indices above 64 never occur
            default: table_angle <= 9'd0;
        endcase
    end

endmodule

/* src/heading_sequencer.sv */
`timescale 1ns/10ps

module heading_sequencer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   div_done,
    input  heading_pkg::angle_t    table_angle,
    input  logic                   swapped,
    input  heading_pkg::quadrant_t quadrant,
    input  logic                   heading_ack,
    output logic                   div_start,
    output logic                   busy,
    output heading_pkg::angle_t    heading,
    output logic                   heading_req
);
    import heading_pkg::*;

    core_state_t state;
    angle_t      base_angle;
    angle_t      composed;

    //////////////////////////////
    // Unfold base angle into the full circle
    always_comb begin
        case (quadrant)
            2'd0: composed = base_angle;
            2'd1: composed = angle_t'(HALF_CIRCLE) - base_angle;
            2'd2: composed = angle_t'(HALF_CIRCLE) + base_angle;
            default: begin
                composed = angle_t'(FULL_CIRCLE) - base_angle;
                // 360 wraps to 0
                if (composed == angle_t'(FULL_CIRCLE)) begin
                    composed = '0;
                end
            end
        endcase
    end

    //////////////////////////////
    // Control FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= CORE_IDLE;
            div_start   <= 1'b0;
            heading_req <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    // Fold registers on this edge, divider starts right after
                    if (start) begin
                        div_start <= 1'b1;
                        state     <= CORE_FOLD;
                    end
                end
                CORE_FOLD:    state <= CORE_DIVIDE;
                CORE_DIVIDE: begin
                    if (div_done) begin
                        state <= CORE_LOOKUP;
                    end
                end
                CORE_LOOKUP:  state <= CORE_COMPOSE;
                CORE_COMPOSE: begin
                    heading_req <= 1'b1;
                    state       <= CORE_PRESENT;
                end
                CORE_PRESENT: begin
                    if (heading_ack) begin
                        heading_req <= 1'b0;
                        state       <= CORE_RETIRE;
                    end
                end
                CORE_RETIRE: begin
                    if (!heading_ack) begin
                        state <= CORE_IDLE;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // Heading held from compose until the next sample
    always_ff @(posedge clk) begin
        if (state == CORE_LOOKUP) begin
            base_angle <= swapped ? angle_t'(RIGHT_ANGLE) - table_angle : table_angle;
        end
        if (state == CORE_COMPOSE) begin
            heading <= composed;
        end
    end

    assign busy = (state != CORE_IDLE);

    heading_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        heading_req |-> (heading < angle_t'(FULL_CIRCLE)));

endmodule

/* src/compass_heading_top.sv */
`timescale 1ns/10ps

module compass_heading_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sample_req,
    input  heading_pkg::axis_t  x_in,
    input  heading_pkg::axis_t  y_in,
    input  logic                heading_ack,
    output logic                sample_ack,
    output logic                heading_req,
    output heading_pkg::angle_t heading
);
    import heading_pkg::*;

    axis_t      x_lat;
    axis_t      y_lat;
    logic       start;
    logic       busy;
    mag_t       min_mag;
    mag_t       max_mag;
    logic       swapped;
    quadrant_t  quadrant;
    logic       div_start;
    logic       div_done;
    ratio_idx_t ratio_idx;
    angle_t     table_angle;

    //////////////////////////////
    // Input handshake and fold
    sample_capture capture_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .sample_req (sample_req),
        .x_in       (x_in),
        .y_in       (y_in),
        .busy       (busy),
        .sample_ack (sample_ack),
        .x_lat      (x_lat),
        .y_lat      (y_lat),
        .start      (start)
    );

    octant_fold fold_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .x_lat    (x_lat),
        .y_lat    (y_lat),
        .min_mag  (min_mag),
        .max_mag  (max_mag),
        .swapped  (swapped),
        .quadrant (quadrant)
    );

    //////////////////////////////
    // Ratio, table and output
    ratio_divider divider_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .div_start (div_start),
        .min_mag   (min_mag),
        .max_mag   (max_mag),
        .ratio_idx (ratio_idx),
        .div_done  (div_done)
    );

    atan_rom rom_i (
        .clk         (clk),
        .addr        (ratio_idx),
        .table_angle (table_angle)
    );

    heading_sequencer sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .div_done    (div_done),
        .table_angle (table_angle),
        .swapped     (swapped),
        .quadrant    (quadrant),
        .heading_ack (heading_ack),
        .div_start   (div_start),
        .busy        (busy),
        .heading     (heading),
        .heading_req (heading_req)
    );

endmodule

/* test/heading_model.svh */
`ifndef HEADING_MODEL_SVH
`define HEADING_MODEL_SVH

logic [31:0] lfsr_state = 32'h710f_0430;
int          error_count = 0;

//////////////////////////////
// Galois LFSR, shifts right
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value      = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

//////////////////////////////
// Reference heading
function automatic int atan_degrees(input int idx);
    real rad;
    rad = $atan(idx / 64.0);
    return $rtoi(rad * 180.0 / 3.14159265358979 + 0.5);
endfunction

function automatic int expected_heading(input int x, input int y);
    int ax;
    int ay;
    int idx;
    int a;
    ax  = (x < 0) ? -x : x;
    ay  = (y < 0) ? -y : y;
    // Smaller over larger, floor of 64 times the ratio
    if (ay > ax) begin
        idx = (ax * 64) / ay;
    end else begin
        idx = (ax == 0) ? 0 : (ay * 64) / ax;
    end
    a = atan_degrees(idx);
    if (ay > ax) begin
        a = 90 - a;
    end
    if (x >= 0 && y >= 0) begin
        return a;
    end else if (x < 0 && y >= 0) begin
        return 180 - a;
    end else if (x < 0) begin
        return 180 + a;
    end
    return (360 - a) % 360;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
        error_count++;
    end
endtask

`endif

/* test/tb_compass_heading.sv */
`timescale 1ns/10ps

module tb_compass_heading;

    localparam int TOTAL_SAMPLES = 239;
    localparam int CYCLE_LIMIT   = TOTAL_SAMPLES * 60;

    logic        clk;
    logic        arst_n;
    logic        sample_req;
    logic [15:0] x_in;
    logic [15:0] y_in;
    logic        heading_ack;
    logic        sample_ack;
    logic        heading_req;
    logic [8:0]  heading;

    int    expected_q[$];
    int    sent_count = 0;
    int    received_count = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    test_errors = 0;
    int    cycle_count = 0;
    int    overlap_cycles = 0;
    int    req_rises = 0;
    string stall_point = "reset";

    logic       prev_sample_ack = 1'b0;
    logic       prev_heading_req = 1'b0;
    logic       prev_heading_ack = 1'b0;
    logic       result_open = 1'b0;
    logic       hold_open = 1'b0;
    logic [8:0] held_heading = '0;

    `include "heading_model.svh"

    compass_heading_top dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .sample_req  (sample_req),
        .x_in        (x_in),
        .y_in        (y_in),
        .heading_ack (heading_ack),
        .sample_ack  (sample_ack),
        .heading_req (heading_req),
        .heading     (heading)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, stalled waiting for %s", cycle_count, stall_point);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // Handshake order monitor
    always @(posedge clk) begin
        if (arst_n) begin
            if (prev_heading_ack && !heading_ack) begin
                result_open = 1'b0;
                hold_open   = 1'b0;
            end
            // No new sample while a result is still open
            if (result_open && !prev_sample_ack) begin
                check_value("sample_ack", sample_ack, 1'b0);
            end
            if (sample_ack && !prev_sample_ack) begin
                result_open = 1'b1;
            end
            if (result_open && sample_req) begin
                overlap_cycles++;
            end
            if (heading_req && !prev_heading_req) begin
                held_heading = heading;
                hold_open    = 1'b1;
                req_rises++;
            end else if (hold_open) begin
                check_value("heading", heading, held_heading);
            end
            if (prev_heading_req && !heading_req) begin
                check_value("heading_ack", heading_ack, 1'b1);
            end
        end
        prev_sample_ack  = sample_ack;
        prev_heading_req = heading_req;
        prev_heading_ack = heading_ack;
    end

    //////////////////////////////
    // Consumer side of the output port
    task automatic receive_heading();
        logic [31:0] delay;
        logic [8:0]  value;
        @(posedge clk);
        while (!heading_req) begin
            @(posedge clk);
        end
        value = heading;
        @(negedge clk);
        delay = take_bits(4);
        repeat (delay) @(negedge clk);
        heading_ack = 1'b1;
        @(posedge clk);
        while (heading_req) begin
            @(posedge clk);
        end
        @(negedge clk);
        heading_ack = 1'b0;
        received_count++;
        check_value("heading_in_range", value < 9'd360, 1'b1);
        if (expected_q.size() > 0) begin
            check_value("heading", value, expected_q.pop_front());
        end else begin
            $display("Heading 0x%0h arrived with no sample outstanding", value);
            error_count++;
        end
    endtask

    initial begin
        @(posedge arst_n);
        forever begin
            receive_heading();
        end
    end

    task automatic send_sample(input logic signed [15:0] x, input logic signed [15:0] y,
                               input int expected);
        @(negedge clk);
        x_in       = x;
        y_in       = y;
        sample_req = 1'b1;
        expected_q.push_back(expected);
        sent_count++;
        stall_point = "sample_ack to rise";
        @(posedge clk);
        while (!sample_ack) begin
            @(posedge clk);
        end
        @(negedge clk);
        sample_req  = 1'b0;
        stall_point = "sample_ack to fall";
        @(posedge clk);
        while (sample_ack) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_results();
        stall_point = "the heading_req and heading_ack handshake";
        while (received_count < sent_count) begin
            @(posedge clk);
        end
    endtask

    task automatic run_sample(input logic signed [15:0] x, input logic signed [15:0] y,
                              input int expected);
        send_sample(x, y, expected);
        wait_results();
    endtask

    task automatic run_model_sample(input logic signed [15:0] x, input logic signed [15:0] y);
        run_sample(x, y, expected_heading(x, y));
    endtask

    task automatic begin_test();
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        check_value("result_count", received_count, sent_count);
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: FAIL with %0d errors", name, error_count - test_errors);
        end
    endtask

    //////////////////////////////
    // Test sequence
    initial begin
        logic signed [15:0] rx;
        logic signed [15:0] ry;
        arst_n      = 1'b0;
        sample_req  = 1'b0;
        x_in        = '0;
        y_in        = '0;
        heading_ack = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        begin_test();
        check_value("sample_ack", sample_ack, 1'b0);
        check_value("heading_req", heading_req, 1'b0);
        run_sample(16'sd100, 16'sd0, 0);
        end_test("1 reset and first sample");

        begin_test();
        run_sample(16'sd1000, 16'sd0, 0);
        run_sample(16'sd0, 16'sd1000, 90);
        run_sample(-16'sd1000, 16'sd0, 180);
        run_sample(16'sd0, -16'sd1000, 270);
        run_sample(16'sd500, 16'sd500, 45);
        run_sample(-16'sd500, 16'sd500, 135);
        run_sample(-16'sd500, -16'sd500, 225);
        run_sample(16'sd500, -16'sd500, 315);
        // One vector inside each octant
        run_model_sample(16'sd1000, 16'sd300);
        run_model_sample(16'sd300, 16'sd1000);
        run_model_sample(-16'sd300, 16'sd1000);
        run_model_sample(-16'sd1000, 16'sd300);
        run_model_sample(-16'sd1000, -16'sd300);
        run_model_sample(-16'sd300, -16'sd1000);
        run_model_sample(16'sd300, -16'sd1000);
        run_model_sample(16'sd1000, -16'sd300);
        end_test("2 fixed vectors");

        begin_test();
        repeat (200) begin
            rx = take_bits(16);
            ry = take_bits(16);
            run_model_sample(rx, ry);
        end
        end_test("3 random samples");

        begin_test();
        run_sample(16'sd0, 16'sd0, 0);
        run_model_sample(-16'sd32768, 16'sd0);
        run_model_sample(16'sd0, -16'sd32768);
        run_model_sample(-16'sd32768, -16'sd32768);
        run_model_sample(16'sd32767, -16'sd32768);
        run_model_sample(16'sd30000, -16'sd1);
        end_test("4 edge values");

        // Back-to-back requests while results are pending
        begin_test();
        overlap_cycles = 0;
        repeat (8) begin
            rx = take_bits(16);
            ry = take_bits(16);
            send_sample(rx, ry, expected_heading(rx, ry));
        end
        wait_results();
        check_value("overlap_seen", overlap_cycles > 0, 1'b1);
        end_test("5 back-pressure");

        begin_test();
        repeat (8) begin
            rx = take_bits(16);
            ry = take_bits(16);
            send_sample(rx, ry, expected_heading(rx, ry));
        end
        wait_results();
        check_value("heading_req_rises", req_rises, sent_count);
        end_test("6 protocol order");

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+test
src/heading_pkg.sv
src/sample_capture.sv
src/octant_fold.sv
src/ratio_divider.sv
src/atan_rom.sv
src/heading_sequencer.sv
src/compass_heading_top.sv
test/tb_compass_heading.sv
